// ==== compile.f ====
serdes_link_pkg.sv
serdes_cfg_pkg.sv
serdes_cfg_regs.sv
link_ctrl.sv
tx_serializer.sv
rx_deserializer.sv
io_serdes_top.sv
tb_io_serdes.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the serial link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_io_serdes
./obj_dir/Vtb_io_serdes > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Run failed, see sim.log"
  exit 1
fi
echo "Run passed"

// ==== tb_io_serdes.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_io_serdes
  import serdes_link_pkg::*, serdes_cfg_pkg::*;
();

  // Five tests of at most about 100 cycles each, with margin
  localparam int timeout_cycles = 600;

  logic                  ioclk;
  logic                  axis_rst_n;
  logic                  axi_awvalid;
  logic [addr_w-1:0]     axi_awaddr;
  logic                  axi_wvalid;
  logic [cfg_data_w-1:0] axi_wdata;
  logic [cfg_strb_w-1:0] axi_wstrb;
  logic                  axi_arvalid;
  logic [addr_w-1:0]     axi_araddr;
  logic                  axi_rready;
  logic                  cc_is_enable;
  axis_beat_t            as_is_beat;
  wire                   axi_awready;
  wire                   axi_wready;
  wire                   axi_arready;
  wire                   axi_rvalid;
  wire [cfg_data_w-1:0]  axi_rdata;
  wire axis_beat_t       is_as_beat;
  wire                   is_as_tready;
  wire                   core_beat;
  wire                   serial_tclk;
  wire [serial_w-1:0]    serial_loop;  // txd looped straight back to rxd

  integer     seed;
  int         cycle_count = 0;
  int         check_count = 0;
  int         error_count = 0;
  logic       model_on    = 1'b0;
  axis_beat_t exp_rx_1;     // Expected on is_as_beat one core beat from now
  axis_beat_t exp_rx_2;     // Expected on is_as_beat now
  logic [2:0] offer_ready;  // tready of the last three offered beats

  io_serdes_top io_serdes_top_inst (
    .ioclk        (ioclk),
    .axis_rst_n   (axis_rst_n),
    .axi_awvalid  (axi_awvalid),
    .axi_awaddr   (axi_awaddr),
    .axi_awready  (axi_awready),
    .axi_wvalid   (axi_wvalid),
    .axi_wdata    (axi_wdata),
    .axi_wstrb    (axi_wstrb),
    .axi_wready   (axi_wready),
    .axi_arvalid  (axi_arvalid),
    .axi_araddr   (axi_araddr),
    .axi_arready  (axi_arready),
    .axi_rvalid   (axi_rvalid),
    .axi_rdata    (axi_rdata),
    .axi_rready   (axi_rready),
    .cc_is_enable (cc_is_enable),
    .as_is_beat   (as_is_beat),
    .is_as_beat   (is_as_beat),
    .is_as_tready (is_as_tready),
    .core_beat    (core_beat),
    .serial_txd   (serial_loop),
    .serial_tclk  (serial_tclk),
    .serial_rxd   (serial_loop)
  );

  always #2 ioclk = ~ioclk;

  always @(posedge ioclk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // Check helpers
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1) else begin
      error_count++;
      $display("Failure at time %0t: %s", $time, what);
    end
  endtask

  function automatic axis_beat_t idle_beat();
    axis_beat_t b;
    b        = '0;
    b.tready = 1'b1;  // Idle but ready
    return b;
  endfunction

  task automatic random_beat(input logic ready_bit, output axis_beat_t b);
    logic [31:0] r;
    b.tdata  = $random(seed);
    r        = $random(seed);
    b.tstrb  = r[3:0];
    b.tkeep  = r[7:4];
    b.tid    = r[9:8];
    b.tuser  = r[11:10];
    b.tlast  = r[12];
    b.tvalid = 1'b1;
    b.tready = ready_bit;
  endtask

  ////////////////////
  // Stream driving and link model
  // Received beat and ready are checked on every cycle up to the next core beat
  task automatic wait_core_beat();
    do begin
      @(negedge ioclk);
      if (model_on) begin
        check_value("is_as_beat", 64'(is_as_beat), 64'(exp_rx_2));
        check_value("is_as_tready", 64'(is_as_tready), 64'(offer_ready[2]));
      end
    end while (!core_beat);
  endtask

  // Offer one beat; a beat shows up on is_as_beat one core beat after capture,
  // ready seen by the capture is the tready offered three beats back
  task automatic drive_beat(input axis_beat_t offer);
    axis_beat_t sent;
    wait_core_beat();
    as_is_beat  = offer;
    sent        = offer;
    sent.tvalid = offer.tvalid & offer_ready[2];  // Dropped when far side not ready
    exp_rx_2    = exp_rx_1;
    exp_rx_1    = sent;
    offer_ready = {offer_ready[1:0], offer.tready};
  endtask

  // Fill the link with idle beats so the model starts from a known state
  task automatic sync_model();
    model_on = 1'b0;
    repeat (3) drive_beat(idle_beat());
    exp_rx_1    = idle_beat();
    exp_rx_2    = idle_beat();
    offer_ready = 3'b111;
    model_on    = 1'b1;
  endtask

  task automatic check_tclk_running();
    @(posedge ioclk);
    #1;
    check_value("serial_tclk", 64'(serial_tclk), 64'h1);
    @(negedge ioclk);
    #1;
    check_value("serial_tclk", 64'(serial_tclk), 64'h0);
  endtask

  ////////////////////
  // AXI-lite access
  task automatic axil_write(input logic [addr_w-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic enable);
    @(negedge ioclk);
    cc_is_enable = enable;
    axi_awvalid  = 1'b1;
    axi_awaddr   = addr;
    axi_wvalid   = 1'b1;
    axi_wdata    = data;
    axi_wstrb    = strb;
    #1;
    check_value("axi_awready", 64'(axi_awready), 64'(enable));
    check_value("axi_wready", 64'(axi_wready), 64'(enable));
    @(negedge ioclk);
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
  endtask

  task automatic read_ctrl(input logic [addr_w-1:0] addr, input logic [31:0] exp);
    @(negedge ioclk);
    axi_arvalid = 1'b1;
    axi_araddr  = addr;
    #1;
    check_value("axi_arready", 64'(axi_arready), 64'h1);
    check_value("axi_rvalid", 64'(axi_rvalid), 64'h1);
    check_value("axi_rdata", 64'(axi_rdata), 64'(exp));
    @(negedge ioclk);
    axi_arvalid = 1'b0;
  endtask

  ////////////////////
  // Directed tests
  task automatic test_reset_state();
    axis_beat_t b;
    for (int i = 0; i < 6 * clk_ratio; i++) begin
      @(posedge ioclk);
      #1;  // Mid high phase, tclk would show here
      check_value("serial_txd", 64'(serial_loop), 64'h0);
      check_value("serial_tclk", 64'(serial_tclk), 64'h0);
      check_value("is_as_tready", 64'(is_as_tready), 64'h0);
      check_value("is_as_beat.tvalid", 64'(is_as_beat.tvalid), 64'h0);
      @(negedge ioclk);
      // Phase starts at 0 on reset release and counts every ioclk
      check_value("core_beat", 64'(core_beat),
                  64'(((i + 1) % clk_ratio) == (clk_ratio - 1)));
      if (core_beat) begin
        random_beat(1'b1, b);
        as_is_beat = b;
      end
    end
    as_is_beat = idle_beat();
  endtask

  task automatic test_register_access();
    axil_write(15'h0000, 32'h3, 4'hf, 1'b0);  // Config access disabled
    read_ctrl(15'h0000, 32'h0);
    axil_write(15'h0004, 32'h3, 4'hf, 1'b1);  // Other offset
    read_ctrl(15'h0000, 32'h0);
    axil_write(15'h0000, 32'h3, 4'he, 1'b1);  // Strobe bit 0 clear
    read_ctrl(15'h0008, 32'h0);
    axil_write(15'h0000, 32'h3, 4'h1, 1'b1);
    read_ctrl(15'h0004, 32'h3);               // Read address ignored
  endtask

  task automatic test_loopback();
    axis_beat_t b;
    logic       seen_ready;
    seen_ready = 1'b0;
    for (int i = 0; i < 12 && !seen_ready; i++) begin
      drive_beat(idle_beat());
      seen_ready = is_as_tready;
    end
    check_true(seen_ready, "is_as_tready did not rise after enabling both directions");
    check_tclk_running();
    sync_model();
    for (int i = 0; i < 16; i++) begin
      random_beat(1'b1, b);
      drive_beat(b);
    end
    repeat (2) drive_beat(idle_beat());  // Drain the last two beats
  endtask

  task automatic test_back_pressure();
    axis_beat_t b;
    for (int i = 0; i < 6; i++) begin
      random_beat(1'b0, b);
      drive_beat(b);
    end
    check_value("is_as_tready", 64'(is_as_tready), 64'h0);
    check_value("is_as_beat.tvalid", 64'(is_as_beat.tvalid), 64'h0);
    for (int i = 0; i < 6; i++) begin
      random_beat(1'b1, b);
      drive_beat(b);
    end
    check_value("is_as_tready", 64'(is_as_tready), 64'h1);
    repeat (2) drive_beat(idle_beat());
  endtask

  task automatic test_sticky_enables();
    axis_beat_t b;
    axil_write(15'h0000, 32'h0, 4'hf, 1'b1);
    read_ctrl(15'h0000, 32'h0);
    check_tclk_running();  // Enables stay set
    sync_model();
    for (int i = 0; i < 8; i++) begin
      random_beat(1'b1, b);
      drive_beat(b);
    end
    repeat (2) drive_beat(idle_beat());
  endtask

  initial begin
    seed         = 32'he4e2;
    ioclk        = 1'b0;
    axis_rst_n   = 1'b0;
    axi_awvalid  = 1'b0;
    axi_awaddr   = '0;
    axi_wvalid   = 1'b0;
    axi_wdata    = '0;
    axi_wstrb    = '0;
    axi_arvalid  = 1'b0;
    axi_araddr   = '0;
    axi_rready   = 1'b1;
    cc_is_enable = 1'b0;
    as_is_beat   = idle_beat();
    exp_rx_1     = '0;
    exp_rx_2     = '0;
    offer_ready  = '0;
    repeat (5) @(negedge ioclk);
    axis_rst_n = 1'b1;

    test_reset_state();
    test_register_access();
    test_loopback();
    test_back_pressure();
    test_sticky_enables();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== io_serdes_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module io_serdes_top
  import serdes_link_pkg::*, serdes_cfg_pkg::*;
(
  input  wire                    ioclk,
  input  wire                    axis_rst_n,
  // AXI-lite config port
  input  wire                    axi_awvalid,
  input  wire [addr_w-1:0]       axi_awaddr,
  output wire                    axi_awready,
  input  wire                    axi_wvalid,
  input  wire [cfg_data_w-1:0]   axi_wdata,
  input  wire [cfg_strb_w-1:0]   axi_wstrb,
  output wire                    axi_wready,
  input  wire                    axi_arvalid,
  input  wire [addr_w-1:0]       axi_araddr,
  output wire                    axi_arready,
  output wire                    axi_rvalid,
  output wire [cfg_data_w-1:0]   axi_rdata,
  input  wire                    axi_rready,
  input  wire                    cc_is_enable,
  // Stream side
  input  wire axis_beat_t        as_is_beat,    // tready here is our receive readiness
  output wire axis_beat_t        is_as_beat,
  output wire                    is_as_tready,
  output wire                    core_beat,     // Present and sample while high
  // Serial lines
  output wire [serial_w-1:0]     serial_txd,
  output wire                    serial_tclk,
  input  wire [serial_w-1:0]     serial_rxd
);

  serdes_ctrl_t       ctrl;
  logic [phase_w-1:0] phase;
  logic               txen;
  logic               rxen;
  logic               rx_frame_done;
  logic               rx_remote_ready;

  assign core_beat = (phase == last_phase);

  ////////////////////
  // Config and control
  serdes_cfg_regs serdes_cfg_regs_inst (
    .ioclk        (ioclk),
    .axis_rst_n   (axis_rst_n),
    .cc_is_enable (cc_is_enable),
    .axi_awvalid  (axi_awvalid),
    .axi_awaddr   (axi_awaddr),
    .axi_awready  (axi_awready),
    .axi_wvalid   (axi_wvalid),
    .axi_wdata    (axi_wdata),
    .axi_wstrb    (axi_wstrb),
    .axi_wready   (axi_wready),
    .axi_arvalid  (axi_arvalid),
    .axi_araddr   (axi_araddr),
    .axi_arready  (axi_arready),
    .axi_rvalid   (axi_rvalid),
    .axi_rdata    (axi_rdata),
    .axi_rready   (axi_rready),
    .ctrl         (ctrl)
  );

  link_ctrl link_ctrl_inst (
    .ioclk           (ioclk),
    .axis_rst_n      (axis_rst_n),
    .ctrl            (ctrl),
    .rx_frame_done   (rx_frame_done),
    .rx_remote_ready (rx_remote_ready),
    .phase           (phase),
    .txen            (txen),
    .rxen            (rxen),
    .is_as_tready    (is_as_tready)
  );

  ////////////////////
  // Datapath
  tx_serializer tx_serializer_inst (
    .ioclk        (ioclk),
    .axis_rst_n   (axis_rst_n),
    .phase        (phase),
    .txen         (txen),
    .is_as_tready (is_as_tready),
    .as_is_beat   (as_is_beat),
    .serial_txd   (serial_txd),
    .serial_tclk  (serial_tclk)
  );

  rx_deserializer rx_deserializer_inst (
    .ioclk           (ioclk),
    .axis_rst_n      (axis_rst_n),
    .phase           (phase),
    .rxen            (rxen),
    .serial_rxd      (serial_rxd),
    .is_as_beat      (is_as_beat),
    .rx_frame_done   (rx_frame_done),
    .rx_remote_ready (rx_remote_ready)
  );

endmodule

`default_nettype wire

// ==== rx_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_deserializer
  import serdes_link_pkg::*;
(
  input  wire                 ioclk,
  input  wire                 axis_rst_n,
  input  wire [phase_w-1:0]   phase,
  input  wire                 rxen,
  input  wire [serial_w-1:0]  serial_rxd,
  output axis_beat_t          is_as_beat,
  output logic                rx_frame_done,
  output logic                rx_remote_ready
);

  lane_frame_t shift_q;
  lane_frame_t shift_d;  // Slots including the bit on the lines now
  logic        frame_end;

  assign frame_end = rxen && (phase == last_phase);

  // New bit enters at the top, phase 0 bit ends up in slot bit 0
  always_comb begin
    for (int i = 0; i < serial_w; i++) begin
      shift_d[i] = {serial_rxd[i], shift_q[i][clk_ratio-1:1]};
    end
  end

  ////////////////////
  // Sampling
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      shift_q <= '0;
    end else if (rxen) begin
      shift_q <= shift_d;
    end
  end

  // Output beat, loaded with the last phase bit taken straight from the lines
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      is_as_beat    <= '0;
      rx_frame_done <= 1'b0;
    end else begin
      rx_frame_done <= frame_end;  // One cycle pulse
      if (frame_end) begin
        is_as_beat <= lanes_to_beat(shift_d);
      end
    end
  end

  // Ready bit sent by the far side
  assign rx_remote_ready = is_as_beat.tready;

endmodule

`default_nettype wire

// ==== tx_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_serializer
  import serdes_link_pkg::*;
(
  input  wire                 ioclk,
  input  wire                 axis_rst_n,
  input  wire [phase_w-1:0]   phase,
  input  wire                 txen,
  input  wire                 is_as_tready,  // Far side can take data
  input  wire axis_beat_t     as_is_beat,
  output logic [serial_w-1:0] serial_txd,
  output logic                serial_tclk
);

  axis_beat_t  frame_q;  // Beat on the lines this core beat
  lane_frame_t lanes;

  ////////////////////
  // Beat capture
  // A beat offered while the far side is not ready goes out as idle,
  // the source has to offer it again
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      frame_q <= '0;
    end else if (!txen) begin
      frame_q <= '0;
    end else if (phase == last_phase) begin
      frame_q        <= as_is_beat;
      frame_q.tvalid <= as_is_beat.tvalid & is_as_tready;
    end
  end

  assign lanes = beat_to_lanes(frame_q);

  ////////////////////
  // Lane select
  always_comb begin
    for (int i = 0; i < serial_w; i++) begin
      serial_txd[i] = lanes[i][phase] & txen;  // One bit per lane per phase
    end
  end

  // Forwarded clock, quiet until the link is up
  assign serial_tclk = ioclk & txen;

endmodule

`default_nettype wire

// ==== link_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module link_ctrl
  import serdes_link_pkg::*, serdes_cfg_pkg::*;
(
  input  wire                 ioclk,
  input  wire                 axis_rst_n,
  input  wire serdes_ctrl_t   ctrl,
  input  wire                 rx_frame_done,    // Pulse per received beat
  input  wire logic           rx_remote_ready,  // Far side ready, from the link
  output logic [phase_w-1:0]  phase,
  output logic                txen,
  output logic                rxen,
  output logic                is_as_tready
);

  logic beat_edge;
  logic rx_received;  // Any frame seen since reset

  assign beat_edge = (phase == last_phase);

  ////////////////////
  // Phase counter
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;  // Free running, wraps every core beat
    end
  end

  ////////////////////
  // Sticky enables
  // A frame from the far side also opens the transmit path, so
  // our ready reaches a peer that came up first
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      txen <= 1'b0;
    end else if (beat_edge && (ctrl.txen_ctl || rx_received)) begin
      txen <= 1'b1;
    end
  end

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rxen <= 1'b0;
    end else if (ctrl.rxen_ctl) begin
      rxen <= 1'b1;
    end
  end

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rx_received <= 1'b0;
    end else if (rx_frame_done) begin
      rx_received <= 1'b1;
    end
  end

  // Stream ready, updated once per core beat
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      is_as_tready <= 1'b0;
    end else if (beat_edge) begin
      if (!txen) begin
        is_as_tready <= 1'b0;
      end else if (!rx_received) begin
        is_as_tready <= 1'b1;             // Nothing heard yet, avoid deadlock
      end else begin
        is_as_tready <= rx_remote_ready;  // Follow the far side
      end
    end
  end

endmodule

`default_nettype wire

// ==== serdes_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module serdes_cfg_regs
  import serdes_cfg_pkg::*;
(
  input  wire                    ioclk,
  input  wire                    axis_rst_n,
  input  wire                    cc_is_enable,   // Config access enable
  // Write address and data
  input  wire                    axi_awvalid,
  input  wire [addr_w-1:0]       axi_awaddr,
  output logic                   axi_awready,
  input  wire                    axi_wvalid,
  input  wire [cfg_data_w-1:0]   axi_wdata,
  input  wire [cfg_strb_w-1:0]   axi_wstrb,
  output logic                   axi_wready,
  // Read address and data
  input  wire                    axi_arvalid,
  input  wire [addr_w-1:0]       axi_araddr,
  output logic                   axi_arready,
  output logic                   axi_rvalid,
  output logic [cfg_data_w-1:0]  axi_rdata,
  input  wire                    axi_rready,
  output serdes_ctrl_t           ctrl
);

  logic write_fire;
  logic ctrl_hit;

  // Address and data must arrive together
  assign write_fire  = axi_awvalid & axi_wvalid & cc_is_enable;
  assign axi_awready = write_fire;
  assign axi_wready  = write_fire;

  assign ctrl_hit = (axi_awaddr[word_msb:word_lsb] == ctrl_offset) && axi_wstrb[0];

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      ctrl <= '0;
    end else if (write_fire && ctrl_hit) begin
      ctrl.rxen_ctl <= axi_wdata[rxen_bit];
      ctrl.txen_ctl <= axi_wdata[txen_bit];
    end
  end

  ////////////////////
  // Read side
  // Single register, so the read address is not decoded
  assign axi_arready = 1'b1;
  assign axi_rvalid  = 1'b1;

  always_comb begin
    axi_rdata           = '0;
    axi_rdata[rxen_bit] = ctrl.rxen_ctl;
    axi_rdata[txen_bit] = ctrl.txen_ctl;
  end

endmodule

`default_nettype wire

// ==== serdes_cfg_pkg.sv ====
`default_nettype none

package serdes_cfg_pkg;

  ////////////////////
  // AXI-lite widths
  localparam int addr_w     = 15;
  localparam int cfg_data_w = 32;
  localparam int cfg_strb_w = cfg_data_w / 8;

  // Word address decode window within the byte address
  localparam int word_msb = 11;
  localparam int word_lsb = 2;

  ////////////////////
  // Register map
  localparam logic [word_msb-word_lsb:0] ctrl_offset = '0;  // Control register

  // Control register bits
  localparam int rxen_bit = 0;
  localparam int txen_bit = 1;

  typedef struct packed {
    logic txen_ctl;  // Requests the transmit path
    logic rxen_ctl;  // Requests the receive path
  } serdes_ctrl_t;

endpackage

`default_nettype wire

// ==== serdes_link_pkg.sv ====
`default_nettype none

package serdes_link_pkg;

  ////////////////////
  // Beat timing and widths
  localparam int clk_ratio  = 4;               // ioclk cycles per core beat
  localparam int phase_w    = 2;
  localparam int data_w     = 32;
  localparam int strb_w     = data_w / 8;
  localparam int data_lanes = data_w / clk_ratio;
  localparam int serial_w   = data_lanes + 4;  // Data lanes plus four sideband lanes

  // Sideband lanes sit above the data lanes
  localparam int lane_strb    = data_lanes;
  localparam int lane_keep    = data_lanes + 1;
  localparam int lane_id_user = data_lanes + 2;
  localparam int lane_ctrl    = data_lanes + 3;

  localparam logic [phase_w-1:0] last_phase = phase_w'(clk_ratio - 1);

  typedef struct packed {
    logic [data_w-1:0] tdata;
    logic [strb_w-1:0] tstrb;
    logic [strb_w-1:0] tkeep;
    logic [1:0]        tid;
    logic [1:0]        tuser;
    logic              tlast;
    logic              tvalid;
    logic              tready;
  } axis_beat_t;

  // One nibble per lane, bit k is on the line during phase k
  typedef logic [serial_w-1:0][clk_ratio-1:0] lane_frame_t;

  ////////////////////
  // Lane mapping, shared by both directions
  function automatic lane_frame_t beat_to_lanes(axis_beat_t beat);
    lane_frame_t lanes;
    for (int j = 0; j < data_lanes; j++) begin
      lanes[j] = beat.tdata[j*clk_ratio +: clk_ratio];
    end
    lanes[lane_strb]    = beat.tstrb;
    lanes[lane_keep]    = beat.tkeep;
    lanes[lane_id_user] = {beat.tid, beat.tuser};
    lanes[lane_ctrl]    = {1'b0, beat.tlast, beat.tvalid, beat.tready};  // Phase 3 idle
    return lanes;
  endfunction

  function automatic axis_beat_t lanes_to_beat(lane_frame_t lanes);
    axis_beat_t beat;
    for (int j = 0; j < data_lanes; j++) begin
      beat.tdata[j*clk_ratio +: clk_ratio] = lanes[j];
    end
    beat.tstrb                             = lanes[lane_strb];
    beat.tkeep                             = lanes[lane_keep];
    {beat.tid, beat.tuser}                 = lanes[lane_id_user];
    {beat.tlast, beat.tvalid, beat.tready} = lanes[lane_ctrl][2:0];
    return beat;
  endfunction

endpackage

`default_nettype wire
